/* src/board_pkg.sv */
`default_nettype none

package board_pkg;

    // Address map of the board bus
    // UART data register, one word
    localparam logic [31:0] uart_base = 32'h8000_0000;
    // Keyboard status word, reserved and unmapped for writes
    localparam logic [31:0] key_base  = 32'h8000_0010;

    // PS/2 receiver timing
    // Cycles without a falling edge before a partial frame is dropped
    localparam int ps2_idle_cycles = 512;
    localparam int ps2_idle_w      = $clog2(ps2_idle_cycles);
    localparam logic [ps2_idle_w-1:0] ps2_idle_last = ps2_idle_w'(ps2_idle_cycles - 1);

    // UART transmitter timing
    // Clock cycles per serial bit
    localparam int uart_baud_div = 64;
    localparam int uart_div_w    = $clog2(uart_baud_div);
    localparam logic [uart_div_w-1:0] uart_div_last = uart_div_w'(uart_baud_div - 1);

    // Transmit FIFO sizing
    localparam int uart_fifo_depth = 4;
    localparam int fifo_ptr_w      = $clog2(uart_fifo_depth);
    // Count needs one extra state for the full condition
    localparam int fifo_cnt_w      = $clog2(uart_fifo_depth + 1);
    localparam logic [fifo_cnt_w-1:0] fifo_full_count = fifo_cnt_w'(uart_fifo_depth);

    // One bus write request, we is a single-cycle strobe
    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] wdata;
        logic        we;
    } bus_req_t;

endpackage

`default_nettype wire

/* src/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none

module ps2_receiver (
    input  wire logic       CLOCK_50,
    input  wire logic       rst_n,
    input  wire logic       ps2_clk_async,
    input  wire logic       ps2_data_async,
    output logic      [7:0] code,
    output logic            code_valid,
    output logic            frame_error
);

    // Two-stage synchronisers with bit 1 as the safe copy
    logic [1:0] clk_sync;
    logic [1:0] dat_sync;
    // Edge register for the PS/2 clock
    logic       clk_prev;
    logic       fall;
    // Start, data and parity bits in LSB-first order
    logic [9:0] shift;
    logic [3:0] bit_cnt;
    logic [board_pkg::ps2_idle_w-1:0] idle_cnt;
    logic       start_ok;
    logic       parity_ok;
    logic       stop_ok;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            // Both lines idle high
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk_async};
            dat_sync <= {dat_sync[0], ps2_data_async};
            clk_prev <= clk_sync[1];
        end
    end

    // Keyboard changes data on the rising edge, so sample on the falling one
    assign fall = clk_prev & ~clk_sync[1];

    // Frame checks evaluated while the stop bit is on the line
    assign start_ok  = ~shift[0];
    // Odd parity over eight data bits plus the parity bit
    assign parity_ok = ^shift[9:1];
    assign stop_ok   = dat_sync[1];

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt     <= '0;
            idle_cnt    <= '0;
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            code_valid  <= 1'b0;
            frame_error <= 1'b0;
            if (fall) begin
                idle_cnt <= '0;
                if (bit_cnt == 4'd10) begin
                    // Eleventh bit closes the frame
                    bit_cnt <= '0;
                    if (start_ok && parity_ok && stop_ok) begin
                        code_valid <= 1'b1;
                    end else begin
                        frame_error <= 1'b1;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Keyboard went quiet mid-frame so resync on the next start bit
                if (idle_cnt == board_pkg::ps2_idle_last) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Shift register and code latch
    always_ff @(posedge CLOCK_50) begin
        if (fall && bit_cnt != 4'd10) begin
            shift <= {dat_sync[1], shift[9:1]};
        end
        if (fall && bit_cnt == 4'd10) begin
            code <= shift[8:1];
        end
    end

    // A frame ends in exactly one verdict
    a_one_verdict: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        !(code_valid && frame_error));

endmodule

`default_nettype wire

/* src/scan_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_decoder (
    input  wire logic           CLOCK_50,
    input  wire logic           rst_n,
    input  wire logic     [7:0] code,
    input  wire logic           code_valid,
    output board_pkg::bus_req_t bus
);

    // Set after F0 and consumed by the released key's code
    logic       break_pending;
    logic       is_prefix;
    logic       we_q;
    logic [7:0] ascii;
    logic [7:0] byte_q;

    assign is_prefix = (code == 8'hF0);

    // Set-2 make codes to ASCII
    always_comb begin
        case (code)
            8'h45:   ascii = 8'h30;
            8'h16:   ascii = 8'h31;
            8'h1E:   ascii = 8'h32;
            8'h26:   ascii = 8'h33;
            8'h25:   ascii = 8'h34;
            8'h2E:   ascii = 8'h35;
            8'h36:   ascii = 8'h36;
            8'h3D:   ascii = 8'h37;
            8'h3E:   ascii = 8'h38;
            8'h46:   ascii = 8'h39;
            // Space bar
            8'h29:   ascii = 8'h20;
            // Enter gives carriage return
            8'h5A:   ascii = 8'h0D;
            // Anything else shows up as a question mark
            default: ascii = 8'h3F;
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            break_pending <= 1'b0;
            we_q          <= 1'b0;
        end else begin
            we_q <= 1'b0;
            if (code_valid) begin
                if (is_prefix) begin
                    break_pending <= 1'b1;
                end else if (break_pending) begin
                    // Key release is swallowed
                    break_pending <= 1'b0;
                end else begin
                    we_q <= 1'b1;
                end
            end
        end
    end

    // Byte held until the next make code
    always_ff @(posedge CLOCK_50) begin
        if (code_valid && !is_prefix && !break_pending) begin
            byte_q <= ascii;
        end
    end

    // Every write goes to the UART data word
    assign bus = '{addr: board_pkg::uart_base, wdata: {24'h00_0000, byte_q}, we: we_q};

endmodule

`default_nettype wire

/* src/bus_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_decoder (
    input  wire logic                 CLOCK_50,
    input  wire logic                 rst_n,
    input  wire board_pkg::bus_req_t  bus,
    input  wire logic                 full,
    output logic                      push,
    output logic                [7:0] push_data,
    output logic                [7:0] ledg,
    output logic                [7:0] drop_count
);

    logic uart_sel;
    logic uart_wr;

    // Exact word match without partial decode
    assign uart_sel = (bus.addr == board_pkg::uart_base);
    assign uart_wr  = bus.we && uart_sel;

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            push       <= 1'b0;
            ledg       <= '0;
            drop_count <= '0;
        end else begin
            push <= uart_wr && !full;
            if (uart_wr) begin
                // LEDs echo every byte whether sent or dropped
                ledg <= bus.wdata[7:0];
                // Saturate so the red LEDs stay all on
                if (full && drop_count != 8'hFF) begin
                    drop_count <= drop_count + 8'd1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (uart_wr) begin
            push_data <= bus.wdata[7:0];
        end
    end

    // FIFO overflow guard
    a_push_not_full: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        push |-> !full);

endmodule

`default_nettype wire

/* src/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire logic       CLOCK_50,
    input  wire logic       rst_n,
    input  wire logic       push,
    input  wire logic [7:0] push_data,
    output logic            full,
    output logic            busy,
    output logic            txd
);

    // FIFO storage and pointers
    logic [7:0] mem [board_pkg::uart_fifo_depth];
    logic [board_pkg::fifo_ptr_w-1:0] wr_ptr;
    logic [board_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [board_pkg::fifo_cnt_w-1:0] count;
    logic push_ok;
    logic pop;
    // Serializer state
    logic active;
    logic [board_pkg::uart_div_w-1:0] baud_cnt;
    logic [3:0] bit_cnt;
    // Stop, data and start bits with the line bit at 0
    logic [9:0] shift;
    logic baud_tick;
    logic frame_done;

    assign full       = (count == board_pkg::fifo_full_count);
    assign push_ok    = push && !full;
    assign baud_tick  = active && (baud_cnt == board_pkg::uart_div_last);
    assign frame_done = baud_tick && (bit_cnt == 4'd9);
    // Load when idle or straight after a stop bit for gapless bytes
    assign pop        = (count != '0) && (!active || frame_done);
    assign txd        = shift[0];
    assign busy       = active || (count != '0);

    always_ff @(posedge CLOCK_50) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            // Pointers wrap on their own since the depth is a power of two
            if (push_ok) wr_ptr <= wr_ptr + 1'b1;
            if (pop)     rd_ptr <= rd_ptr + 1'b1;
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLOCK_50 or negedge rst_n) begin
        if (!rst_n) begin
            active   <= 1'b0;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            // Line idles high
            shift    <= '1;
        end else if (pop) begin
            shift    <= {1'b1, mem[rd_ptr], 1'b0};
            active   <= 1'b1;
            baud_cnt <= '0;
            bit_cnt  <= '0;
        end else if (baud_tick) begin
            // Ones shift in so the line rests high after the stop bit
            shift    <= {1'b1, shift[9:1]};
            baud_cnt <= '0;
            if (bit_cnt == 4'd9) begin
                active <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 4'd1;
            end
        end else if (active) begin
            baud_cnt <= baud_cnt + 1'b1;
        end
    end

    a_count_bound: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        count <= board_pkg::fifo_full_count);

endmodule

`default_nettype wire

/* src/keyboard_monitor_top.sv */
`timescale 1ns/1ps
`default_nettype none

module keyboard_monitor_top (
    input  wire       CLOCK_50,
    input  wire       rst_n,
    input  wire       PS2_CLK,
    input  wire       PS2_DAT,
    output wire [7:0] LEDG,
    output wire       LEDR9,
    output wire [7:0] LEDR7_0,
    output wire       uart_txd
);

    // Keyboard to decoder
    logic [7:0] code;
    logic       code_valid;
    // Board bus, write only
    board_pkg::bus_req_t bus;
    // Bus decoder to transmitter
    logic       push;
    logic [7:0] push_data;
    logic       full;

    ps2_receiver u_ps2_receiver (
        .CLOCK_50       (CLOCK_50),
        .rst_n          (rst_n),
        .ps2_clk_async  (PS2_CLK),
        .ps2_data_async (PS2_DAT),
        .code           (code),
        .code_valid     (code_valid),
        // Bad frames are simply dropped at board level
        .frame_error    ()
    );

    scan_decoder u_scan_decoder (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .code       (code),
        .code_valid (code_valid),
        .bus        (bus)
    );

    // Red LEDs show the drop count, green echoes the last byte
    bus_decoder u_bus_decoder (
        .CLOCK_50   (CLOCK_50),
        .rst_n      (rst_n),
        .bus        (bus),
        .full       (full),
        .push       (push),
        .push_data  (push_data),
        .ledg       (LEDG),
        .drop_count (LEDR7_0)
    );

    // Leftmost red LED lights while bytes are pending
    uart_tx u_uart_tx (
        .CLOCK_50  (CLOCK_50),
        .rst_n     (rst_n),
        .push      (push),
        .push_data (push_data),
        .full      (full),
        .busy      (LEDR9),
        .txd       (uart_txd)
    );

endmodule

`default_nettype wire

/* dv/tb_keyboard_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_keyboard_monitor;

    // PS/2 clock half-period in system cycles
    localparam int ps2_half = 16;
    localparam int ps2_frame_cycles = 11 * 2 * ps2_half;
    localparam int uart_frame_cycles = 10 * board_pkg::uart_baud_div;
    // Singles, break pair, unmapped, parity pair, then the burst
    localparam int n_frames = 12 + 2 + 1 + 1 + 2 + 12;
    localparam int n_bytes = 12 + 1 + 1 + 1 + 12;
    localparam int watchdog_cycles = n_frames * ps2_frame_cycles
        + n_bytes * uart_frame_cycles + 20 * board_pkg::ps2_idle_cycles;

    // Mapped set-2 make codes and their characters
    localparam logic [7:0] key_codes [0:11] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E,
                                                8'h36, 8'h3D, 8'h3E, 8'h46, 8'h29, 8'h5A};
    localparam logic [7:0] key_chars [0:11] = '{8'h30, 8'h31, 8'h32, 8'h33, 8'h34, 8'h35,
                                                8'h36, 8'h37, 8'h38, 8'h39, 8'h20, 8'h0D};

    logic       CLOCK_50;
    logic       rst_n;
    logic       PS2_CLK;
    logic       PS2_DAT;
    logic [7:0] LEDG;
    logic       LEDR9;
    logic [7:0] LEDR7_0;
    logic       uart_txd;

    // Bytes seen on the serial line and the model's bytes
    logic [7:0] rx_q [$];
    logic [7:0] exp_q [$];
    bit         break_seen;
    bit         frame_started;
    bit         burst_started;
    int         idx;

    keyboard_monitor_top u_keyboard_monitor_top (
        .CLOCK_50 (CLOCK_50),
        .rst_n    (rst_n),
        .PS2_CLK  (PS2_CLK),
        .PS2_DAT  (PS2_DAT),
        .LEDG     (LEDG),
        .LEDR9    (LEDR9),
        .LEDR7_0  (LEDR7_0),
        .uart_txd (uart_txd)
    );

    initial begin
        CLOCK_50 = 1'b0;
        forever #2 CLOCK_50 = ~CLOCK_50;
    end

    // Step n edges then settle past the edge
    task automatic wait_cycles(input int n);
        repeat (n) @(posedge CLOCK_50);
        #1;
    endtask

    function automatic logic [7:0] ascii_of(input logic [7:0] code);
        logic [7:0] ch;
        // Unknown keys print as a question mark
        ch = 8'h3F;
        for (int i = 0; i < 12; i++) begin
            if (key_codes[i] == code) ch = key_chars[i];
        end
        return ch;
    endfunction

    // Break prefix swallows the next code and F0 itself sends nothing
    task automatic model_key(input logic [7:0] code);
        if (code == 8'hF0) begin
            break_seen = 1'b1;
        end else if (break_seen) begin
            break_seen = 1'b0;
        end else begin
            exp_q.push_back(ascii_of(code));
        end
    endtask

    // Keyboard frame of start bit, data LSB first, parity and stop
    task automatic send_frame(input logic [7:0] code, input bit bad_parity);
        logic [10:0] bits;
        logic        par;
        par = ~^code;
        if (bad_parity) par = ~par;
        bits = {1'b1, par, code, 1'b0};
        frame_started = 1'b1;
        for (int i = 0; i < 11; i++) begin
            // Data moves while PS2_CLK is high
            PS2_DAT = bits[i];
            wait_cycles(ps2_half);
            PS2_CLK = 1'b0;
            wait_cycles(ps2_half);
            PS2_CLK = 1'b1;
        end
        PS2_DAT = 1'b1;
        if (!bad_parity) model_key(code);
    endtask

    task automatic check_next();
        logic [7:0] got;
        logic [7:0] want;
        while (rx_q.size() == 0) wait_cycles(1);
        got = rx_q.pop_front();
        a_byte_expected: assert (exp_q.size() != 0) else begin
            $display("A byte arrived on the UART line although none was expected");
            $display("=== FAIL ===");
            $fatal(1);
        end
        want = exp_q.pop_front();
        a_rx_byte: assert (got == want) else begin
            $display("Error: uart_txd byte 0x%02h, expected 0x%02h", got, want);
            $display("=== FAIL ===");
            $fatal(1);
        end
        // Echo lands well before the stop bit
        a_ledg_echo: assert (LEDG == want) else begin
            $display("Error: LEDG 0x%02h, expected 0x%02h", LEDG, want);
            $display("=== FAIL ===");
            $fatal(1);
        end
    endtask

    // Received bytes must keep their order among the expected ones
    function automatic bit rx_in_order();
        int j;
        j = 0;
        for (int k = 0; k < rx_q.size(); k++) begin
            while (j < exp_q.size() && exp_q[j] != rx_q[k]) j++;
            if (j == exp_q.size()) return 1'b0;
            j++;
        end
        return 1'b1;
    endfunction

    // UART line monitor sampling mid-bit on the falling clock
    initial begin : uart_monitor
        logic [7:0] data;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge uart_txd);
            repeat (board_pkg::uart_baud_div / 2) @(negedge CLOCK_50);
            a_start_bit: assert (uart_txd == 1'b0) else begin
                $display("The UART start bit did not hold low to its middle");
                $display("=== FAIL ===");
                $fatal(1);
            end
            for (int i = 0; i < 8; i++) begin
                repeat (board_pkg::uart_baud_div) @(negedge CLOCK_50);
                data[i] = uart_txd;
            end
            repeat (board_pkg::uart_baud_div) @(negedge CLOCK_50);
            a_stop_bit: assert (uart_txd == 1'b1) else begin
                $display("The UART stop bit was missing");
                $display("=== FAIL ===");
                $fatal(1);
            end
            rx_q.push_back(data);
        end
    end

    // Quiet outputs until the keyboard speaks
    a_quiet_after_reset: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        !frame_started |-> (uart_txd && LEDG == 8'h00 && LEDR7_0 == 8'h00 && !LEDR9))
        else begin
            $display("Error: idle outputs uart_txd=%0h LEDG=0x%02h LEDR7_0=0x%02h LEDR9=%0h",
                     uart_txd, LEDG, LEDR7_0, LEDR9);
            $display("=== FAIL ===");
            $fatal(1);
        end

    // Sparse traffic never fills the FIFO
    a_no_early_drops: assert property (@(posedge CLOCK_50) disable iff (!rst_n)
        !burst_started |-> LEDR7_0 == 8'h00)
        else begin
            $display("Error: LEDR7_0 0x%02h, expected 0x00", LEDR7_0);
            $display("=== FAIL ===");
            $fatal(1);
        end

    initial begin : watchdog
        repeat (watchdog_cycles) @(posedge CLOCK_50);
        $display("Timeout: the design stopped making progress before the tests finished");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        void'($urandom(92));
        rst_n = 1'b0;
        PS2_CLK = 1'b1;
        PS2_DAT = 1'b1;
        break_seen = 1'b0;
        frame_started = 1'b0;
        burst_started = 1'b0;
        wait_cycles(8);
        rst_n = 1'b1;
        // Idle stretch for the reset checks
        wait_cycles(100);

        // Every mapped key on its own
        for (int i = 0; i < 12; i++) begin
            send_frame(key_codes[i], 1'b0);
            check_next();
        end

        // Release of the 1 key followed by a 2 press
        send_frame(8'hF0, 1'b0);
        send_frame(8'h16, 1'b0);
        send_frame(8'h1E, 1'b0);
        check_next();

        // Unmapped key
        send_frame(8'h1C, 1'b0);
        check_next();

        // Corrupted 0 followed by a clean 9
        send_frame(8'h45, 1'b1);
        send_frame(8'h46, 1'b0);
        check_next();

        a_queues_drained: assert (rx_q.size() == 0 && exp_q.size() == 0) else begin
            $display("Bytes were left over before the burst test");
            $display("=== FAIL ===");
            $fatal(1);
        end

        // Frames faster than the serial line can drain
        burst_started = 1'b1;
        for (int i = 0; i < 12; i++) begin
            idx = int'($urandom % 32'd12);
            send_frame(key_codes[idx], 1'b0);
        end
        wait_cycles(8);
        while (LEDR9) wait_cycles(1);

        a_burst_total: assert (rx_q.size() + 32'(LEDR7_0) == 12) else begin
            $display("Error: rx count 0x%0h plus LEDR7_0 0x%02h, expected total 0x0c",
                     rx_q.size(), LEDR7_0);
            $display("=== FAIL ===");
            $fatal(1);
        end
        a_burst_order: assert (rx_in_order()) else begin
            $display("Burst bytes arrived out of order or were never sent");
            $display("=== FAIL ===");
            $fatal(1);
        end
        a_burst_dropped: assert (LEDR7_0 != 8'h00) else begin
            $display("The burst never filled the transmit FIFO");
            $display("=== FAIL ===");
            $fatal(1);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
src/board_pkg.sv
src/ps2_receiver.sv
src/scan_decoder.sv
src/bus_decoder.sv
src/uart_tx.sv
src/keyboard_monitor_top.sv
dv/tb_keyboard_monitor.sv

/* run.sh */
#!/bin/sh
# Build with Verilator, run, and judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert --top-module tb_keyboard_monitor \
    -f project.f -o sim_tb > build.log 2>&1 &&
    ./obj_dir/sim_tb > sim.log 2>&1
grep -q "=== PASS ===" sim.log 2>/dev/null && echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }
